//--- build.f
+incdir+bench
rtl/csr_pkg.sv
rtl/preg_file.sv
rtl/wb_arbiter.sv
rtl/csr_unit.sv
rtl/csr_issue_queue.sv
rtl/csr_subsys_top.sv
bench/tb_csr_subsys.sv

//--- Bender.yml
package:
  name: csr_subsys

sources:
  - files:
      - rtl/csr_pkg.sv
      - rtl/preg_file.sv
      - rtl/wb_arbiter.sv
      - rtl/csr_unit.sv
      - rtl/csr_issue_queue.sv
      - rtl/csr_subsys_top.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_csr_subsys.sv

//--- bench/tb_csr_model.svh
// --------------------------------------------------
// Reference model of the CSR path.
// --------------------------------------------------
typedef struct {
    csr_pkg::csr_op_e   op;
    csr_pkg::csr_addr_t csr;
    csr_pkg::preg_t     rs1;
    csr_pkg::preg_t     rd;
    csr_pkg::rob_idx_t  rob;
} model_op_t;

csr_pkg::xlen_t model_csr  [8]  = '{default: '0};
csr_pkg::xlen_t model_regs [32] = '{default: '0};
model_op_t      exp_q [$];                          // Ops still owed a writeback.

// Same lap compares slots; across a wrap the order flips.
function automatic logic is_older(input logic [5:0] a, input logic [5:0] b);
    if (a[5] != b[5]) begin
        return a[4:0] > b[4:0];
    end
    return a[4:0] < b[4:0];
endfunction

function automatic csr_pkg::xlen_t rmw_result(input csr_pkg::csr_op_e op,
                                              input csr_pkg::xlen_t old_v,
                                              input csr_pkg::xlen_t src);
    case (op)
        csr_pkg::csr_rw: return src;
        csr_pkg::csr_rs: return old_v | src;
        default:         return old_v & ~src;
    endcase
endfunction

// Expected rd value of an op; also moves the model CSR on.
function automatic csr_pkg::xlen_t retire_op(input model_op_t o);
    csr_pkg::xlen_t old_v;
    old_v            = model_csr[o.csr];
    model_csr[o.csr] = rmw_result(o.op, old_v, model_regs[o.rs1]);
    return old_v;
endfunction

function automatic void flush_younger(input logic [5:0] idx);
    model_op_t keep [$];
    foreach (exp_q[i]) begin
        if (!is_older(idx, exp_q[i].rob)) keep.push_back(exp_q[i]);
    end
    exp_q = keep;
endfunction

//--- bench/tb_csr_subsys.sv
`timescale 1ns/1ps

module tb_csr_subsys;

    localparam int       MAX_CYCLES = 4000;         // All six tests need well under 1000.
    localparam bit [5:0] PARK       = 6'd63;        // Commit index that matches no entry.

    logic                 clk, rst;
    logic                 dispatch_en, dispatch_full;
    csr_pkg::csr_bundle_t dispatch_bundle;
    csr_pkg::rob_idx_t    dispatch_rob_idx, commit_rob_idx, redirect_rob_idx;
    logic                 redirect, ext_grant;
    csr_pkg::wb_req_t     ext_wb, prf_wr;

    integer         seed;
    int             cycles      = 0;
    int             wb_count    = 0;
    int             err_count   = 0;
    int             check_count = 0;
    string          test_name   = "reset";
    csr_pkg::xlen_t last_wb_data;

    `include "tb_csr_model.svh"

    csr_subsys_top i_dut (
        .clk              (clk),
        .rst              (rst),
        .dispatch_en      (dispatch_en),
        .dispatch_bundle  (dispatch_bundle),
        .dispatch_rob_idx (dispatch_rob_idx),
        .dispatch_full    (dispatch_full),
        .commit_rob_idx   (commit_rob_idx),
        .redirect         (redirect),
        .redirect_rob_idx (redirect_rob_idx),
        .ext_wb           (ext_wb),
        .ext_grant        (ext_grant),
        .prf_wr           (prf_wr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // --------------------------------------------------
    // Comparison of every register-file write.
    // --------------------------------------------------
    always @(negedge clk) begin
        model_op_t      o;
        csr_pkg::xlen_t exp_v;
        if (!rst && ext_wb.valid) begin
            check_count++;
            if (!ext_grant || !prf_wr.valid || prf_wr.preg != ext_wb.preg ||
                prf_wr.data != ext_wb.data) begin
                $display("%s: external write to preg %0d did not reach the port.",
                         test_name, ext_wb.preg);
                err_count++;
            end
            model_regs[ext_wb.preg] = ext_wb.data;
        end
        else if (!rst && prf_wr.valid) begin
            check_count++;
            if (exp_q.size() == 0) begin
                $display("%s: unexpected CSR writeback to preg %0d.", test_name, prf_wr.preg);
                err_count++;
            end
            else begin
                o     = exp_q.pop_front();
                exp_v = retire_op(o);
                if (prf_wr.preg != o.rd) begin
                    $display("[ERROR] %s: rd expected %0d actual %0d", test_name, o.rd,
                             prf_wr.preg);
                    err_count++;
                end
                if (prf_wr.data != exp_v) begin
                    $display("[ERROR] %s: data expected %h actual %h", test_name, exp_v,
                             prf_wr.data);
                    err_count++;
                end
                wb_count++;
                last_wb_data = prf_wr.data;
            end
            model_regs[prf_wr.preg] = prf_wr.data;
        end
    end

    // --------------------------------------------------
    // Stimulus helpers.
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic dispatch_op(input csr_pkg::csr_op_e op, input int csr, input int rs1,
                               input int rd, input int rob);
        model_op_t o;
        o = '{op: op, csr: csr[2:0], rs1: rs1[4:0], rd: rd[4:0], rob: rob[5:0]};
        dispatch_en      = 1'b1;
        dispatch_bundle  = '{op: op, csr: csr[2:0], rs1: rs1[4:0], rd: rd[4:0]};
        dispatch_rob_idx = rob[5:0];
        if (!dispatch_full && !redirect) exp_q.push_back(o);   // A full queue drops it.
        next_cycle();
        dispatch_en = 1'b0;
    endtask

    task automatic ext_write(input int preg, input csr_pkg::xlen_t data);
        ext_wb = '{valid: 1'b1, preg: preg[4:0], data: data};
        next_cycle();
        ext_wb.valid = 1'b0;
    endtask

    // Commit the oldest owed op and wait for its writeback, until none are left.
    task automatic drain();
        int n;
        while (exp_q.size() > 0) begin
            n              = wb_count;
            commit_rob_idx = exp_q[0].rob;
            while (wb_count == n) next_cycle();
        end
        commit_rob_idx = PARK;
        repeat (8) next_cycle();                    // Room for a stray write to show.
    endtask

    task automatic expect_count(input int got, input int want, input string what);
        check_count++;
        if (got != want) begin
            $display("[ERROR] %s: %s expected %0d actual %0d", test_name, what, want, got);
            err_count++;
        end
    endtask

    task automatic end_test(input int errs_before);
        $display("Test %s: %0d errors", test_name, err_count - errs_before);
    endtask

    initial begin
        int             base;
        int             n;
        csr_pkg::xlen_t seed_vals [16];
        seed             = 32'h9f95fa98;
        rst              = 1'b1;
        dispatch_en      = 1'b0;
        dispatch_bundle  = '0;
        dispatch_rob_idx = '0;
        commit_rob_idx   = PARK;
        redirect         = 1'b0;
        redirect_rob_idx = '0;
        ext_wb           = '0;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        expect_count(dispatch_full, 0, "dispatch_full after reset");
        expect_count(prf_wr.valid, 0, "prf_wr.valid after reset");

        test_name = "seed";
        base      = err_count;
        for (int r = 1; r < 16; r++) begin
            seed_vals[r] = $random(seed);
            ext_write(r, seed_vals[r]);
        end
        dispatch_op(csr_pkg::csr_rw, 2, 5, 16, 1);
        dispatch_op(csr_pkg::csr_rs, 2, 0, 17, 2);  // Zero source reads the CSR back.
        drain();
        check_count++;
        if (last_wb_data != seed_vals[5]) begin
            $display("[ERROR] %s: csr expected %h actual %h", test_name, seed_vals[5],
                     last_wb_data);
            err_count++;
        end
        end_test(base);

        test_name = "rmw";
        base      = err_count;
        for (int c = 0; c < 8; c++) begin
            for (int k = 0; k < 4; k++) begin
                dispatch_op(k == 0 ? csr_pkg::csr_rw : (k == 2 ? csr_pkg::csr_rc : csr_pkg::csr_rs),
                            c, 1 + ({$random(seed)} % 15), 16 + ((4 * c + k) % 15),
                            3 + 4 * c + k);
            end
            drain();
        end
        end_test(base);

        test_name = "commit";
        base      = err_count;
        n         = wb_count;
        for (int k = 0; k < 4; k++) begin
            dispatch_op(csr_pkg::csr_rs, k, 1 + k, 20 + k, 30 + k); // 31 wraps to 32.
        end
        repeat (20) next_cycle();
        expect_count(wb_count - n, 0, "writebacks before commit");
        drain();
        expect_count(wb_count - n, 4, "writebacks");
        end_test(base);

        test_name = "full";
        base      = err_count;
        n         = wb_count;
        for (int k = 0; k < 8; k++) dispatch_op(csr_pkg::csr_rc, k, 1 + k, 16 + k, 40 + k);
        expect_count(dispatch_full, 1, "dispatch_full");
        dispatch_op(csr_pkg::csr_rw, 0, 9, 28, 48);
        dispatch_op(csr_pkg::csr_rw, 1, 9, 29, 49);
        drain();
        expect_count(wb_count - n, 8, "writebacks");
        end_test(base);

        test_name = "redirect";
        base      = err_count;
        n         = wb_count;
        for (int k = 0; k < 6; k++) dispatch_op(csr_pkg::csr_rs, k, 1 + k, 16 + k, 10 + k);
        redirect         = 1'b1;
        redirect_rob_idx = 6'd12;
        flush_younger(6'd12);
        next_cycle();
        redirect = 1'b0;
        dispatch_op(csr_pkg::csr_rw, 6, 3, 24, 13);
        dispatch_op(csr_pkg::csr_rc, 7, 4, 25, 14);
        drain();
        expect_count(wb_count - n, 5, "writebacks");
        end_test(base);

        test_name = "contention";
        base      = err_count;
        dispatch_op(csr_pkg::csr_rs, 3, 7, 26, 20);
        n              = wb_count;
        ext_wb         = '{valid: 1'b1, preg: 5'd31, data: '0};
        commit_rob_idx = 6'd20;
        for (int k = 0; k < 20; k++) begin
            ext_wb.data = $random(seed);
            next_cycle();
        end
        ext_wb.valid = 1'b0;
        next_cycle();                               // Held write takes the first free cycle.
        expect_count(wb_count - n, 1, "writebacks once external traffic stops");
        drain();
        expect_count(wb_count - n, 1, "writebacks");
        end_test(base);

        $display("Tests: 6, checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end
        else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/csr_subsys_top.sv
`timescale 1ns/1ps

module csr_subsys_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch_en,
    input  csr_pkg::csr_bundle_t dispatch_bundle,
    input  csr_pkg::rob_idx_t    dispatch_rob_idx,
    output logic                 dispatch_full,
    input  csr_pkg::rob_idx_t    commit_rob_idx,
    input  logic                 redirect,
    input  csr_pkg::rob_idx_t    redirect_rob_idx,
    input  csr_pkg::wb_req_t     ext_wb,
    output logic                 ext_grant,
    output csr_pkg::wb_req_t     prf_wr
);

    csr_pkg::preg_t      rd_preg;
    csr_pkg::xlen_t      rd_data;
    logic                csr_ready;
    logic                issue_valid;
    csr_pkg::csr_issue_t issue;
    csr_pkg::wb_req_t    csr_wb;
    logic                csr_grant;

    csr_issue_queue i_iq (
        .clk              (clk),
        .rst              (rst),
        .dispatch_en      (dispatch_en),
        .dispatch_bundle  (dispatch_bundle),
        .dispatch_rob_idx (dispatch_rob_idx),
        .dispatch_full    (dispatch_full),
        .commit_rob_idx   (commit_rob_idx),
        .redirect         (redirect),
        .redirect_rob_idx (redirect_rob_idx),
        .rd_preg          (rd_preg),
        .rd_data          (rd_data),
        .csr_ready        (csr_ready),
        .issue_valid      (issue_valid),
        .issue            (issue)
    );

    preg_file i_prf (
        .clk     (clk),
        .rst     (rst),
        .rd_preg (rd_preg),
        .rd_data (rd_data),
        .wr      (prf_wr)
    );

    csr_unit i_csr (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .csr_ready   (csr_ready),
        .wb          (csr_wb),
        .grant       (csr_grant)
    );

    wb_arbiter i_arb (
        .ext       (ext_wb),
        .csr       (csr_wb),
        .ext_grant (ext_grant),
        .csr_grant (csr_grant),
        .wr        (prf_wr)
    );

endmodule

//--- rtl/csr_issue_queue.sv
`timescale 1ns/1ps

module csr_issue_queue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch_en,
    input  csr_pkg::csr_bundle_t dispatch_bundle,
    input  csr_pkg::rob_idx_t    dispatch_rob_idx,
    output logic                 dispatch_full,
    input  csr_pkg::rob_idx_t    commit_rob_idx,
    input  logic                 redirect,
    input  csr_pkg::rob_idx_t    redirect_rob_idx,
    output csr_pkg::preg_t       rd_preg,
    input  csr_pkg::xlen_t       rd_data,
    input  logic                 csr_ready,
    output logic                 issue_valid,
    output csr_pkg::csr_issue_t  issue
);

    typedef struct packed {
        csr_pkg::csr_bundle_t bundle;
        csr_pkg::rob_idx_t    rob_idx;
    } iq_entry_t;

    iq_entry_t                    entries [csr_pkg::IQ_SIZE];
    logic [csr_pkg::IQ_SIZE-1:0]  dir_tbl;     // Tail direction at each enqueue.
    logic [csr_pkg::IQ_WIDTH-1:0] head, tail;
    logic [csr_pkg::IQ_WIDTH-1:0] head_n, tail_n;
    logic                         hdir, tdir;
    logic [csr_pkg::IQ_WIDTH:0]   count;
    logic                         empty, full;
    logic                         enqueue, select;
    logic                         s1_valid, s2_valid;
    csr_pkg::csr_issue_t          s1_op, s2_op;
    logic                         any_keep;
    logic [csr_pkg::IQ_WIDTH-1:0] last_keep, keep_n;

    assign head_n = head + 1'b1;
    assign tail_n = tail + 1'b1;
    assign count  = {tdir, tail} - {hdir, head};
    assign empty  = (head == tail) && (hdir == tdir);
    assign full   = (head == tail) && (hdir != tdir);

    assign dispatch_full = full;
    assign enqueue       = dispatch_en && !full && !redirect;

    // --------------------------------------------------
    // Select against commit and read rs1.
    // --------------------------------------------------
    // The two pipeline valids cover the gap before the unit goes busy.
    assign select = !empty && (entries[head].rob_idx == commit_rob_idx) && !redirect &&
                    csr_ready && !s1_valid && !s2_valid;

    assign rd_preg = entries[head].bundle.rs1;

    always_ff @(posedge clk) begin
        if (enqueue) begin
            entries[tail] <= '{bundle: dispatch_bundle, rob_idx: dispatch_rob_idx};
        end
    end

    // --------------------------------------------------
    // Redirect recovery.
    // --------------------------------------------------
    // Walk from head while entries survive the redirect.
    always_comb begin
        logic [csr_pkg::IQ_WIDTH-1:0] slot;
        logic                         run;
        run       = 1'b1;
        any_keep  = 1'b0;
        last_keep = head;
        for (int k = 0; k < csr_pkg::IQ_SIZE; k++) begin
            slot = head + k[csr_pkg::IQ_WIDTH-1:0];
            if (run && (k < count) &&
                !csr_pkg::rob_older(redirect_rob_idx, entries[slot].rob_idx)) begin
                any_keep  = 1'b1;
                last_keep = slot;
            end
            else begin
                run = 1'b0;
            end
        end
    end

    assign keep_n = last_keep + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            hdir    <= 1'b0;
            tdir    <= 1'b0;
            dir_tbl <= '0;
        end
        else begin
            if (redirect) begin
                if (!any_keep) begin
                    tail <= head;                   // Nothing survives.
                    tdir <= hdir;
                end
                else begin
                    tail <= keep_n;
                    tdir <= (keep_n == '0) ? ~dir_tbl[last_keep] : dir_tbl[last_keep];
                end
            end
            else if (enqueue) begin
                tail          <= tail_n;
                dir_tbl[tail] <= tdir;
                if (tail_n == '0) begin
                    tdir <= ~tdir;
                end
            end

            if (select) begin
                head <= head_n;
                if (head_n == '0) begin
                    hdir <= ~hdir;
                end
            end
        end
    end

    // --------------------------------------------------
    // Issue pipeline.
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else begin
            s1_valid <= select;
            s2_valid <= s1_valid &&
                        !(redirect && csr_pkg::rob_older(redirect_rob_idx, s1_op.rob_idx));
        end
    end

    always_ff @(posedge clk) begin
        if (select) begin
            s1_op <= '{op:      entries[head].bundle.op,
                       csr:     entries[head].bundle.csr,
                       rd:      entries[head].bundle.rd,
                       rob_idx: entries[head].rob_idx,
                       rs1_val: rd_data};
        end
        s2_op <= s1_op;
    end

    assign issue_valid = s2_valid;
    assign issue       = s2_op;

endmodule

//--- rtl/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  csr_pkg::csr_issue_t issue,
    output logic                csr_ready,
    output csr_pkg::wb_req_t    wb,
    input  logic                grant
);

    csr_pkg::xlen_t csrs [csr_pkg::CSR_NUM];
    csr_pkg::xlen_t old_val, new_val;
    logic           busy;
    csr_pkg::preg_t wb_preg;
    csr_pkg::xlen_t wb_data;

    // --------------------------------------------------
    // Read-modify-write.
    // --------------------------------------------------
    assign old_val = csrs[issue.csr];

    always_comb begin
        case (issue.op)
            csr_pkg::csr_rw: new_val = issue.rs1_val;
            csr_pkg::csr_rs: new_val = old_val | issue.rs1_val;
            csr_pkg::csr_rc: new_val = old_val & ~issue.rs1_val;
            default:         new_val = old_val;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            csrs <= '{default: '0};
        end
        else if (issue_valid) begin
            csrs[issue.csr] <= new_val;
        end
    end

    // --------------------------------------------------
    // Writeback hold.
    // --------------------------------------------------
    // Busy from issue until the write port is granted.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end
        else if (issue_valid) begin
            busy <= 1'b1;
        end
        else if (grant) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            wb_preg <= issue.rd;
            wb_data <= old_val;                 // Old CSR value goes to rd.
        end
    end

    assign wb        = '{valid: busy, preg: wb_preg, data: wb_data};
    assign csr_ready = !busy;

endmodule

//--- rtl/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  csr_pkg::wb_req_t ext,
    input  csr_pkg::wb_req_t csr,
    output logic             ext_grant,
    output logic             csr_grant,
    output csr_pkg::wb_req_t wr
);

    // External writeback always wins.
    assign ext_grant = ext.valid;
    assign csr_grant = csr.valid && !ext.valid;

    always_comb begin
        if (ext_grant) begin
            wr = ext;
        end
        else begin
            wr = csr;                           // Idle port when csr.valid is low.
        end
    end

endmodule

//--- rtl/preg_file.sv
`timescale 1ns/1ps

module preg_file (
    input  logic             clk,
    input  logic             rst,
    input  csr_pkg::preg_t   rd_preg,
    output csr_pkg::xlen_t   rd_data,
    input  csr_pkg::wb_req_t wr
);

    csr_pkg::xlen_t regs [csr_pkg::PREG_NUM];

    // Same-cycle write is not forwarded; the read sees the old word.
    assign rd_data = regs[rd_preg];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end
        else if (wr.valid) begin
            regs[wr.preg] <= wr.data;
        end
    end

endmodule

//--- rtl/csr_pkg.sv
package csr_pkg;

    // --------------------------------------------------
    // Sizes.
    // --------------------------------------------------
    localparam int IQ_SIZE    = 8;
    localparam int IQ_WIDTH   = 3;
    localparam int PREG_NUM   = 32;
    localparam int XLEN       = 32;
    localparam int CSR_NUM    = 8;
    localparam int PREG_WIDTH = $clog2(PREG_NUM);
    localparam int CSR_WIDTH  = $clog2(CSR_NUM);
    localparam int ROB_WIDTH  = 6;                 // Wrap bit plus 5 slot bits.

    // --------------------------------------------------
    // Vector types.
    // --------------------------------------------------
    typedef logic [PREG_WIDTH-1:0] preg_t;
    typedef logic [ROB_WIDTH-1:0]  rob_idx_t;
    typedef logic [CSR_WIDTH-1:0]  csr_addr_t;
    typedef logic [XLEN-1:0]       xlen_t;

    typedef enum logic [1:0] {
        csr_rw,
        csr_rs,
        csr_rc
    } csr_op_e;

    // --------------------------------------------------
    // Bundles.
    // --------------------------------------------------
    typedef struct packed {
        csr_op_e   op;
        csr_addr_t csr;
        preg_t     rs1;
        preg_t     rd;
    } csr_bundle_t;

    typedef struct packed {
        csr_op_e   op;
        csr_addr_t csr;
        preg_t     rd;
        rob_idx_t  rob_idx;
        xlen_t     rs1_val;                        // Operand read at select.
    } csr_issue_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
        xlen_t data;
    } wb_req_t;

    // True when a is older than b in the reorder buffer.
    function automatic logic rob_older(input rob_idx_t a, input rob_idx_t b);
        if (a[ROB_WIDTH-1] == b[ROB_WIDTH-1]) begin
            return a[ROB_WIDTH-2:0] < b[ROB_WIDTH-2:0];
        end
        // Different laps, so the larger slot was allocated first.
        return a[ROB_WIDTH-2:0] > b[ROB_WIDTH-2:0];
    endfunction

endpackage
